// File: logic/lc3b_types.sv
package lc3b_types;

typedef logic [15:0] lc3b_word;
typedef logic [2:0] lc3b_reg;
typedef logic [3:0] lc3b_opcode;
typedef logic [2:0] lc3b_aluop;
typedef logic [1:0] lc3b_alumux_sel;

localparam lc3b_opcode op_add = 4'b0001;
localparam lc3b_opcode op_and = 4'b0101;
localparam lc3b_opcode op_not = 4'b1001;
localparam lc3b_opcode op_shf = 4'b1101;
localparam lc3b_opcode op_ldr = 4'b0110;
localparam lc3b_opcode op_str = 4'b0111;

localparam lc3b_aluop alu_add = 3'd0;
localparam lc3b_aluop alu_and = 3'd1;
localparam lc3b_aluop alu_not = 3'd2;
localparam lc3b_aluop alu_pass = 3'd3;
localparam lc3b_aluop alu_sll = 3'd4;
localparam lc3b_aluop alu_srl = 3'd5;
localparam lc3b_aluop alu_sra = 3'd6;

localparam lc3b_alumux_sel bsel_sr2 = 2'd0;
localparam lc3b_alumux_sel bsel_imm5 = 2'd1;
localparam lc3b_alumux_sel bsel_adj6 = 2'd2;
localparam lc3b_alumux_sel bsel_imm4 = 2'd3;

localparam int mem_words = 256; // data memory depth in words

typedef struct packed {
	lc3b_opcode opcode;
	lc3b_reg dr;
	lc3b_reg sr1;
	logic imm_flag;
	logic [1:0] pad;
	lc3b_reg sr2;
} lc3b_reg_form;

// shf reuses this view: imm_flag is the a bit, imm5[4] the d bit
typedef struct packed {
	lc3b_opcode opcode;
	lc3b_reg dr;
	lc3b_reg sr1;
	logic imm_flag;
	logic [4:0] imm5;
} lc3b_imm_form;

typedef struct packed {
	lc3b_opcode opcode;
	lc3b_reg sr_dr; // dr for ldr, source for str
	lc3b_reg base;
	logic [5:0] offset6;
} lc3b_mem_form;

typedef union packed {
	lc3b_reg_form r;
	lc3b_imm_form i;
	lc3b_mem_form m;
} lc3b_instr;

endpackage : lc3b_types

// File: logic/register_file.sv
module register_file import lc3b_types::*; (
	input logic clk,
	input logic reset,
	input lc3b_reg rd_a,
	input lc3b_reg rd_b,
	output lc3b_word a_val,
	output lc3b_word b_val,
	input logic we,
	input lc3b_reg wr_dest,
	input lc3b_word wr_val
);

lc3b_word regs [8];

always_ff @(posedge clk) begin
	if (reset) begin
		for (int i = 0; i < 8; i++) begin
			regs[i] <= '0;
		end
	end else if (we) begin
		regs[wr_dest] <= wr_val;
	end
end

// write-through so a read in the writeback cycle sees the new value
assign a_val = (we && wr_dest == rd_a) ? wr_val : regs[rd_a];
assign b_val = (we && wr_dest == rd_b) ? wr_val : regs[rd_b];

endmodule : register_file

// File: logic/alu.sv
module alu import lc3b_types::*; (
	input lc3b_aluop aluop,
	input lc3b_word a,
	input lc3b_word b,
	output lc3b_word f
);

logic [3:0] shamt;

assign shamt = b[3:0];

always_comb begin
	case (aluop)
		alu_add: f = a + b;
		alu_and: f = a & b;
		alu_not: f = ~a;
		alu_pass: f = b;
		alu_sll: f = a << shamt;
		alu_srl: f = a >> shamt;
		alu_sra: f = lc3b_word'($signed(a) >>> shamt); // keeps sign bit
		default: f = '0;
	endcase
end

endmodule : alu

// File: logic/forwarding_logic.sv
module forwarding_logic import lc3b_types::*; (
	input lc3b_instr ir,
	input lc3b_reg ex_mem_dest,
	input logic ex_mem_we,
	input lc3b_reg mem_wb_dest,
	input logic mem_wb_we,
	output logic sr1_fwd,
	output logic sr1_from_wb,
	output logic sr2_fwd,
	output logic sr2_from_wb,
	output logic store_fwd,
	output logic store_from_wb
);

logic sr2_used;
logic store_used;
logic sr1_ex, sr1_wb;
logic sr2_ex, sr2_wb;
logic st_ex, st_wb;

assign sr2_used = (ir.r.opcode == op_add || ir.r.opcode == op_and) && !ir.r.imm_flag;
assign store_used = (ir.m.opcode == op_str);

// sr1 field doubles as base for ldr/str
assign sr1_ex = ex_mem_we && (ex_mem_dest == ir.r.sr1);
assign sr1_wb = mem_wb_we && (mem_wb_dest == ir.r.sr1);
assign sr2_ex = ex_mem_we && (ex_mem_dest == ir.r.sr2);
assign sr2_wb = mem_wb_we && (mem_wb_dest == ir.r.sr2);
assign st_ex = ex_mem_we && (ex_mem_dest == ir.m.sr_dr);
assign st_wb = mem_wb_we && (mem_wb_dest == ir.m.sr_dr);

// younger stage wins
assign sr1_fwd = sr1_ex | sr1_wb;
assign sr1_from_wb = !sr1_ex;
assign sr2_fwd = sr2_used & (sr2_ex | sr2_wb);
assign sr2_from_wb = !sr2_ex;
assign store_fwd = store_used & (st_ex | st_wb);
assign store_from_wb = !st_ex;

endmodule : forwarding_logic

// File: logic/decode_stage.sv
module decode_stage import lc3b_types::*; (
	input logic clk,
	input logic reset,
	input lc3b_instr ir,
	input logic valid,
	output lc3b_word sr1_val,
	output lc3b_word sr2_val,
	output lc3b_aluop aluop,
	output lc3b_alumux_sel alumux_sel,
	output logic load_reg,
	output logic mem_read,
	output logic mem_write,
	input logic wb_we,
	input lc3b_reg wb_dest,
	input lc3b_word wb_val
);

lc3b_reg rd_b;

// str reads its data register on port b
assign rd_b = (ir.m.opcode == op_str) ? ir.m.sr_dr : ir.r.sr2;

register_file regs (
	.clk(clk),
	.reset(reset),
	.rd_a(ir.r.sr1),
	.rd_b(rd_b),
	.a_val(sr1_val),
	.b_val(sr2_val),
	.we(wb_we),
	.wr_dest(wb_dest),
	.wr_val(wb_val)
);

always_comb begin
	aluop = alu_add;
	alumux_sel = bsel_sr2;
	load_reg = 1'b0;
	mem_read = 1'b0;
	mem_write = 1'b0;
	if (valid) begin
		case (ir.r.opcode)
			op_add, op_and: begin
				aluop = (ir.r.opcode == op_and) ? alu_and : alu_add;
				alumux_sel = ir.i.imm_flag ? bsel_imm5 : bsel_sr2;
				load_reg = 1'b1;
			end
			op_not: begin
				aluop = alu_not;
				load_reg = 1'b1;
			end
			op_shf: begin
				if (!ir.i.imm5[4]) begin
					aluop = alu_sll;
				end else if (ir.i.imm_flag) begin
					aluop = alu_sra;
				end else begin
					aluop = alu_srl;
				end
				alumux_sel = bsel_imm4;
				load_reg = 1'b1;
			end
			op_ldr: begin
				alumux_sel = bsel_adj6; // base + adj6
				load_reg = 1'b1;
				mem_read = 1'b1;
			end
			op_str: begin
				alumux_sel = bsel_adj6;
				mem_write = 1'b1;
			end
			default: begin
			end
		endcase
	end
end

endmodule : decode_stage

// File: logic/execution_module.sv
module execution_module import lc3b_types::*; (
	input lc3b_instr ir,
	input lc3b_word sr1_val,
	input lc3b_word sr2_val,
	input lc3b_aluop aluop,
	input lc3b_alumux_sel alumux_sel,
	input lc3b_reg ex_mem_dest,
	input logic ex_mem_we,
	input lc3b_word ex_mem_val,
	input lc3b_reg mem_wb_dest,
	input logic mem_wb_we,
	input lc3b_word mem_wb_val,
	output lc3b_word alu_out,
	output lc3b_word store_data
);

lc3b_word sext5, adj6, imm4;
lc3b_word sr1_mux_out, sr2_mux_out, b_mux_out;
logic sr1_fwd, sr1_from_wb;
logic sr2_fwd, sr2_from_wb;
logic store_fwd, store_from_wb;

function automatic lc3b_word fwd_mux(
	input logic fwd,
	input logic from_wb,
	input lc3b_word reg_val,
	input lc3b_word ex_val,
	input lc3b_word wb_val
);
	if (!fwd) begin
		return reg_val;
	end
	return from_wb ? wb_val : ex_val;
endfunction

assign sext5 = {{11{ir.i.imm5[4]}}, ir.i.imm5};
assign adj6 = {{9{ir.m.offset6[5]}}, ir.m.offset6, 1'b0}; // word offset to bytes
assign imm4 = {12'h000, ir.i.imm5[3:0]};

forwarding_logic fwd (
	.ir(ir),
	.ex_mem_dest(ex_mem_dest),
	.ex_mem_we(ex_mem_we),
	.mem_wb_dest(mem_wb_dest),
	.mem_wb_we(mem_wb_we),
	.sr1_fwd(sr1_fwd),
	.sr1_from_wb(sr1_from_wb),
	.sr2_fwd(sr2_fwd),
	.sr2_from_wb(sr2_from_wb),
	.store_fwd(store_fwd),
	.store_from_wb(store_from_wb)
);

assign sr1_mux_out = fwd_mux(sr1_fwd, sr1_from_wb, sr1_val, ex_mem_val, mem_wb_val);
assign sr2_mux_out = fwd_mux(sr2_fwd, sr2_from_wb, sr2_val, ex_mem_val, mem_wb_val);
assign store_data = fwd_mux(store_fwd, store_from_wb, sr2_val, ex_mem_val, mem_wb_val);

always_comb begin
	case (alumux_sel)
		bsel_sr2: b_mux_out = sr2_mux_out;
		bsel_imm5: b_mux_out = sext5;
		bsel_adj6: b_mux_out = adj6;
		default: b_mux_out = imm4; // shift amount
	endcase
end

alu alu_i (
	.aluop(aluop),
	.a(sr1_mux_out),
	.b(b_mux_out),
	.f(alu_out)
);

endmodule : execution_module

// File: logic/memory_stage.sv
module memory_stage import lc3b_types::*; (
	input logic clk,
	input logic reset,
	input lc3b_word addr,
	input lc3b_word store_data,
	input logic mem_read,
	input logic mem_write,
	output lc3b_word result
);

lc3b_word mem [mem_words];
logic [$clog2(mem_words)-1:0] idx;

// byte address, word aligned
assign idx = addr[$clog2(mem_words):1];

always_ff @(posedge clk) begin
	if (reset) begin
		for (int i = 0; i < mem_words; i++) begin
			mem[i] <= '0;
		end
	end else if (mem_write) begin
		mem[idx] <= store_data;
	end
end

// load data is ready in the same cycle
assign result = mem_read ? mem[idx] : addr;

endmodule : memory_stage

// File: logic/lc3b_pipe.sv
module lc3b_pipe import lc3b_types::*; (
	input logic clk,
	input logic reset,
	input logic instr_valid,
	input lc3b_word instr,
	output logic wb_valid,
	output lc3b_reg wb_dest,
	output lc3b_word wb_val
);

logic if_id_valid;
lc3b_instr if_id_ir;

lc3b_word id_sr1_val, id_sr2_val;
lc3b_aluop id_aluop;
lc3b_alumux_sel id_alumux_sel;
logic id_load_reg, id_mem_read, id_mem_write;

lc3b_instr id_ex_ir;
lc3b_word id_ex_sr1_val, id_ex_sr2_val;
lc3b_aluop id_ex_aluop;
lc3b_alumux_sel id_ex_alumux_sel;
logic id_ex_load_reg, id_ex_mem_read, id_ex_mem_write;

lc3b_word ex_alu_out, ex_store_data;

lc3b_reg ex_mem_dest;
lc3b_word ex_mem_alu_out, ex_mem_store_data;
logic ex_mem_load_reg, ex_mem_mem_read, ex_mem_mem_write;
lc3b_word mem_result;

logic mem_wb_we;
lc3b_reg mem_wb_dest;
lc3b_word mem_wb_val;

// control flags
always_ff @(posedge clk) begin
	if (reset) begin
		if_id_valid <= 1'b0;
		id_ex_aluop <= alu_add;
		id_ex_alumux_sel <= bsel_sr2;
		id_ex_load_reg <= 1'b0;
		id_ex_mem_read <= 1'b0;
		id_ex_mem_write <= 1'b0;
		ex_mem_load_reg <= 1'b0;
		ex_mem_mem_read <= 1'b0;
		ex_mem_mem_write <= 1'b0;
		mem_wb_we <= 1'b0;
	end else begin
		if_id_valid <= instr_valid;
		id_ex_aluop <= id_aluop;
		id_ex_alumux_sel <= id_alumux_sel;
		id_ex_load_reg <= id_load_reg;
		id_ex_mem_read <= id_mem_read;
		id_ex_mem_write <= id_mem_write;
		ex_mem_load_reg <= id_ex_load_reg;
		ex_mem_mem_read <= id_ex_mem_read;
		ex_mem_mem_write <= id_ex_mem_write;
		mem_wb_we <= ex_mem_load_reg;
	end
end

// payload
always_ff @(posedge clk) begin
	if_id_ir <= instr;
	id_ex_ir <= if_id_ir;
	id_ex_sr1_val <= id_sr1_val;
	id_ex_sr2_val <= id_sr2_val;
	ex_mem_dest <= id_ex_ir.r.dr; // same bits as ldr dr
	ex_mem_alu_out <= ex_alu_out;
	ex_mem_store_data <= ex_store_data;
	mem_wb_dest <= ex_mem_dest;
	mem_wb_val <= mem_result;
end

decode_stage decode (
	.clk(clk),
	.reset(reset),
	.ir(if_id_ir),
	.valid(if_id_valid),
	.sr1_val(id_sr1_val),
	.sr2_val(id_sr2_val),
	.aluop(id_aluop),
	.alumux_sel(id_alumux_sel),
	.load_reg(id_load_reg),
	.mem_read(id_mem_read),
	.mem_write(id_mem_write),
	.wb_we(mem_wb_we),
	.wb_dest(mem_wb_dest),
	.wb_val(mem_wb_val)
);

execution_module execute (
	.ir(id_ex_ir),
	.sr1_val(id_ex_sr1_val),
	.sr2_val(id_ex_sr2_val),
	.aluop(id_ex_aluop),
	.alumux_sel(id_ex_alumux_sel),
	.ex_mem_dest(ex_mem_dest),
	.ex_mem_we(ex_mem_load_reg),
	.ex_mem_val(mem_result), // covers load-use
	.mem_wb_dest(mem_wb_dest),
	.mem_wb_we(mem_wb_we),
	.mem_wb_val(mem_wb_val),
	.alu_out(ex_alu_out),
	.store_data(ex_store_data)
);

memory_stage memory (
	.clk(clk),
	.reset(reset),
	.addr(ex_mem_alu_out),
	.store_data(ex_mem_store_data),
	.mem_read(ex_mem_mem_read),
	.mem_write(ex_mem_mem_write),
	.result(mem_result)
);

assign wb_valid = mem_wb_we;
assign wb_dest = mem_wb_dest;
assign wb_val = mem_wb_val;

endmodule : lc3b_pipe

// File: testbench/tb_lc3b_pipe.sv
module tb_lc3b_pipe import lc3b_types::*; ();

timeunit 1ns;
timeprecision 100ps;

localparam logic [1:0] shf_left = 2'b00;
localparam logic [1:0] shf_right_log = 2'b01;
localparam logic [1:0] shf_right_arith = 2'b11;

logic clk = 1'b0;
logic reset;
logic instr_valid;
lc3b_word instr;
logic wb_valid;
lc3b_reg wb_dest;
lc3b_word wb_val;

lc3b_word model_regs [8];
lc3b_word model_mem [mem_words];
lc3b_reg exp_dest [$];
lc3b_word exp_val [$];
int errors = 0;
int issued = 0;
int cycles = 0;

lc3b_pipe u_dut (.*);

always #10 clk = ~clk;

always @(posedge clk) begin
	cycles++;
	if (cycles > 40 * issued + 100) begin
		$display("timeout: run stopped after %0d cycles", cycles);
		$display("TESTBENCH FAILED");
		$finish;
	end
end

// writebacks must come in issue order
always @(negedge clk) begin
	if (wb_valid === 1'b1) begin
		assert (exp_dest.size() > 0) else begin
			errors++;
			$display("unexpected writeback to R%0d at %0t", wb_dest, $time);
		end
		if (exp_dest.size() > 0) begin
			assert (wb_dest == exp_dest[0] && wb_val == exp_val[0]) else begin
				errors++;
				$display("Mismatch at %0t: wrote R%0d = %h, expected R%0d = %h",
					$time, wb_dest, wb_val, exp_dest[0], exp_val[0]);
			end
			void'(exp_dest.pop_front());
			void'(exp_val.pop_front());
		end
	end
end

function automatic lc3b_word operate(lc3b_opcode op, lc3b_reg dr, lc3b_reg sr1, int src2,
	logic imm);
	return imm ? {op, dr, sr1, 1'b1, 5'(src2)} : {op, dr, sr1, 3'b000, 3'(src2)};
endfunction

function automatic lc3b_word not_op(lc3b_reg dr, lc3b_reg sr);
	return {op_not, dr, sr, 6'h3f};
endfunction

function automatic lc3b_word shift_op(lc3b_reg dr, lc3b_reg sr, logic [1:0] kind, int amt);
	return {op_shf, dr, sr, kind, 4'(amt)};
endfunction

function automatic lc3b_word mem_op(lc3b_opcode op, lc3b_reg r, lc3b_reg base, int off);
	return {op, r, base, 6'(off)};
endfunction

// architectural effect of one instruction
task automatic model_exec(input lc3b_word w);
	lc3b_word a;
	lc3b_word b;
	lc3b_word addr;
	lc3b_word res;
	a = model_regs[w[8:6]];
	b = w[5] ? {{11{w[4]}}, w[4:0]} : model_regs[w[2:0]];
	addr = a + {{9{w[5]}}, w[5:0], 1'b0};
	res = '0;
	case (w[15:12])
		op_add: res = a + b;
		op_and: res = a & b;
		op_not: res = ~a;
		op_shf: res = !w[4] ? a << w[3:0] :
			(w[5] ? lc3b_word'($signed(a) >>> w[3:0]) : a >> w[3:0]);
		op_ldr: res = model_mem[addr[8:1]]; // word index of byte address
		op_str: model_mem[addr[8:1]] = model_regs[w[11:9]];
		default: res = '0;
	endcase
	if (w[15:12] != op_str) begin
		model_regs[w[11:9]] = res;
		exp_dest.push_back(w[11:9]);
		exp_val.push_back(res);
	end
endtask

task automatic issue(input lc3b_word w);
	instr_valid = 1'b1;
	instr = w;
	model_exec(w);
	issued++;
	@(posedge clk);
	#2;
	instr_valid = 1'b0;
endtask

task automatic idle(input int n);
	instr_valid = 1'b0;
	instr = '0;
	repeat (n) begin
		@(posedge clk);
		#2;
	end
endtask

task automatic set_reg(input lc3b_reg r, input int v);
	issue(operate(op_and, r, r, 0, 1));
	issue(operate(op_add, r, r, v, 1));
endtask

task automatic drain();
	int waited;
	waited = 0;
	while (exp_dest.size() > 0 && waited < 10) begin
		@(posedge clk);
		#2;
		waited++;
	end
	assert (exp_dest.size() == 0) else begin
		errors++;
		$display("missing writeback: %0d expected writes never arrived", exp_dest.size());
		exp_dest.delete();
		exp_val.delete();
	end
	idle(3); // catch stray writes
endtask

task automatic first_write();
	int edges;
	repeat (4) begin
		@(negedge clk);
		assert (wb_valid == 1'b0) else begin
			errors++;
			$display("wb_valid went high at %0t with nothing issued", $time);
		end
	end
	@(posedge clk);
	#2;
	issue(operate(op_add, 1, 0, -5, 1));
	edges = 1;
	@(negedge clk);
	while (wb_valid !== 1'b1 && edges < 8) begin
		@(posedge clk);
		edges++;
		@(negedge clk);
	end
	assert (edges == 4) else begin
		errors++;
		$display("writeback came %0d edges after issue instead of 4", edges);
	end
	@(posedge clk);
	#2;
endtask

task automatic independent_ops();
	set_reg(1, 13);
	set_reg(2, -9);
	idle(3);
	issue(operate(op_add, 3, 1, 2, 0));
	issue(operate(op_add, 4, 1, -3, 1));
	issue(operate(op_and, 5, 1, 2, 0));
	issue(operate(op_and, 6, 2, 6, 1));
	issue(not_op(7, 1));
	issue(shift_op(3, 1, shf_left, 3));
	issue(shift_op(4, 2, shf_right_log, 2));
	issue(shift_op(5, 2, shf_right_arith, 2)); // negative source
	issue(shift_op(6, 1, shf_right_arith, 1));
	drain();
endtask

task automatic dependency_chains();
	for (int d = 1; d <= 3; d++) begin
		issue(operate(op_add, 3, 1, d, 1));
		idle(d - 1);
		issue(operate(op_add, 4, 3, 1, 0)); // sr1 dependent
		idle(3);
		issue(not_op(5, 3));
		idle(d - 1);
		issue(operate(op_and, 6, 1, 5, 0)); // sr2 dependent
		idle(3);
		issue(shift_op(7, 2, shf_right_arith, d));
		idle(d - 1);
		issue(operate(op_add, 7, 7, 7, 0));
		idle(3);
	end
	// younger of two R3 writers in flight wins
	issue(operate(op_add, 3, 0, 5, 1));
	issue(operate(op_add, 3, 0, 7, 1));
	issue(operate(op_add, 4, 3, 3, 0));
	drain();
endtask

task automatic memory_ops();
	set_reg(1, 8);
	issue(shift_op(1, 1, shf_left, 2)); // base 32
	issue(operate(op_add, 2, 1, 5, 1));
	issue(mem_op(op_str, 2, 1, 3));
	issue(mem_op(op_ldr, 3, 1, 3));
	issue(operate(op_add, 4, 3, 1, 1)); // load-use
	issue(not_op(5, 1));
	idle(1);
	issue(mem_op(op_str, 5, 1, -4));
	issue(mem_op(op_ldr, 6, 1, -4));
	issue(operate(op_add, 7, 6, 6, 0));
	issue(mem_op(op_ldr, 2, 1, -15)); // never written
	drain();
endtask

task automatic random_mix(input int count);
	lc3b_reg dr;
	lc3b_reg s1;
	lc3b_reg s2;
	logic [1:0] sk;
	int imm;
	int off;
	set_reg(6, 8);
	issue(shift_op(6, 6, shf_left, 3)); // R6 = 64 as base of every load and store
	for (int n = 0; n < count; n++) begin
		dr = 3'($urandom_range(0, 6));
		if (dr == 3'd6) begin
			dr = 3'd7; // base stays fixed
		end
		s1 = 3'($urandom_range(0, 7));
		s2 = 3'($urandom_range(0, 7));
		sk = 2'($urandom_range(0, 2));
		if (sk == 2'b10) begin
			sk = shf_right_arith;
		end
		imm = int'($urandom_range(0, 31)) - 16;
		off = int'($urandom_range(0, 63)) - 32;
		case ($urandom_range(0, 9))
			0: issue(operate(op_add, dr, s1, s2, 0));
			1: issue(operate(op_add, dr, s1, imm, 1));
			2: issue(operate(op_and, dr, s1, s2, 0));
			3: issue(operate(op_and, dr, s1, imm, 1));
			4: issue(not_op(dr, s1));
			5: issue(shift_op(dr, s1, sk, imm));
			6, 7: issue(mem_op(op_ldr, dr, 6, off));
			default: issue(mem_op(op_str, s1, 6, off));
		endcase
		if ($urandom_range(0, 3) == 0) begin
			idle(int'($urandom_range(1, 2)));
		end
	end
	drain();
endtask

initial begin
	void'($urandom(32'hda26));
	model_regs = '{default: '0};
	model_mem = '{default: '0};
	reset = 1'b1;
	instr_valid = 1'b0;
	instr = '0;
	repeat (2) @(posedge clk);
	#2;
	reset = 1'b0;
	first_write();
	independent_ops();
	dependency_chains();
	memory_ops();
	random_mix(300);
	$display("%0d errors over %0d issued instructions", errors, issued);
	if (errors == 0) begin
		$display("TESTBENCH PASSED");
	end else begin
		$display("TESTBENCH FAILED");
	end
	$finish;
end

endmodule : tb_lc3b_pipe

// File: lc3b_pipe.f
logic/lc3b_types.sv
logic/register_file.sv
logic/alu.sv
logic/forwarding_logic.sv
logic/decode_stage.sv
logic/execution_module.sv
logic/memory_stage.sv
logic/lc3b_pipe.sv
testbench/tb_lc3b_pipe.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tb_lc3b_pipe
FILELIST = lc3b_pipe.f
OBJDIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJDIR)
